//--- verilog/lpif_link_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the reduced LPIF die-to-die link
// Lane geometry, packed flit layout, LPIF state and online sync state
////////////////////////////////////////////////////////////////////////////

package lpif_link_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Lane geometry

  // Eight PHY lanes of 40 bits, top bit of each lane is the strobe
  localparam int LANES      = 8;
  localparam int LANE_W     = 40;
  localparam int LANE_PAY_W = 39;

  // Flit payload and packed width
  localparam int DATA_W = 256;
  localparam int FLIT_W = 273;

  ////////////////////////////////////////////////////////////////////////////
  // Link state as carried in the flit

  typedef enum logic [3:0] {
    ST_RESET     = 4'h0,
    ST_ACTIVE    = 4'h1,
    ST_IDLE      = 4'h2,
    ST_LINKRESET = 4'h9,
    ST_RETRAIN   = 4'hb,
    ST_DISABLED  = 4'hc
  } lpif_state_e;

  // Online delayer FSM
  typedef enum logic [1:0] {
    SYNC_OFFLINE = 2'd0,
    SYNC_COUNT   = 2'd1,
    SYNC_ONLINE  = 2'd2
  } sync_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Packed flit, top bit first

  // 1 + 1 + 8 + 1 + 256 + 2 + 4 = 273 bits
  typedef struct packed {
    logic              valid;
    logic              crc_valid;
    logic [7:0]        crc;
    logic              dvalid;
    logic [DATA_W-1:0] data;
    logic [1:0]        protid;
    lpif_state_e       state;
  } lpif_flit_t;

endpackage

//--- verilog/link_online_sync.sv
////////////////////////////////////////////////////////////////////////////
// Online sync for the tx and rx paths
// Each online input must stay high for a programmable count before the
// matching delayed flag goes high
////////////////////////////////////////////////////////////////////////////

module link_online_sync import lpif_link_pkg::*; #(
  parameter int DELAY_W = 16
) (
  input  logic               clk_wr,
  input  logic               rst,
  input  logic               tx_online,
  input  logic               rx_online,
  input  logic [DELAY_W-1:0] delay_x_value,
  input  logic [DELAY_W-1:0] delay_y_value,
  output logic               tx_online_delay,
  output logic               rx_online_delay
);

  // Channel 0 is tx, channel 1 is rx
  logic               online_in  [2];
  logic [DELAY_W-1:0] delay_in   [2];
  logic               online_out [2];

  assign online_in[0] = tx_online;
  assign online_in[1] = rx_online;
  assign delay_in[0]  = delay_x_value;
  assign delay_in[1]  = delay_y_value;

  for (genvar i = 0; i < 2; i++) begin : g_chan
    sync_state_e        state;
    logic [DELAY_W-1:0] cnt;

    always_ff @(posedge clk_wr) begin
      if (rst) begin
        state <= SYNC_OFFLINE;
        cnt   <= '0;
      end else begin
        case (state)
          SYNC_OFFLINE: begin
            // First high sample counts as cycle one
            if (online_in[i]) begin
              if (delay_in[i] <= DELAY_W'(1)) begin
                state <= SYNC_ONLINE;
              end else begin
                state <= SYNC_COUNT;
                cnt   <= delay_in[i] - DELAY_W'(1);
              end
            end
          end
          SYNC_COUNT: begin
            if (!online_in[i]) begin
              state <= SYNC_OFFLINE;
            end else if (cnt == DELAY_W'(1)) begin
              state <= SYNC_ONLINE;
            end else begin
              cnt <= cnt - DELAY_W'(1);
            end
          end
          SYNC_ONLINE: begin
            if (!online_in[i]) state <= SYNC_OFFLINE;
          end
          default: state <= SYNC_OFFLINE;
        endcase
      end
    end

    assign online_out[i] = (state == SYNC_ONLINE);
  end

  assign tx_online_delay = online_out[0];
  assign rx_online_delay = online_out[1];

endmodule

//--- verilog/flit_tx_stripe.sv
////////////////////////////////////////////////////////////////////////////
// Upstream flit striping onto the eight tx lanes
// Strobe per lane, zero lanes while offline, sent flit counter
////////////////////////////////////////////////////////////////////////////

module flit_tx_stripe import lpif_link_pkg::*; #(
  parameter int CNT_W = 16
) (
  input  logic                         clk_wr,
  input  logic                         rst,
  input  logic                         tx_online_delay,
  input  lpif_flit_t                   ustrm_flit,
  output logic [LANES-1:0][LANE_W-1:0] tx_lanes,
  output logic [CNT_W-1:0]             tx_flit_count
);

  // Flit zero-extended to fill all lane payloads
  localparam int STRIPE_W = LANES * LANE_PAY_W;

  logic                take;
  logic [STRIPE_W-1:0] word_ext;

  // Flits offered while offline are simply dropped
  assign take = tx_online_delay & ustrm_flit.valid;

  // Empty payload when nothing is taken this cycle
  assign word_ext = take ? {{(STRIPE_W - FLIT_W){1'b0}}, ustrm_flit} : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Lane registers

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_lanes <= '0;
    end else begin
      for (int k = 0; k < LANES; k++) begin
        if (tx_online_delay) begin
          // Lane k carries word bits 39k and up, strobe on top
          tx_lanes[k] <= {1'b1, word_ext[k*LANE_PAY_W +: LANE_PAY_W]};
        end else begin
          tx_lanes[k] <= '0;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sent flit count

  // Wraps at 2^CNT_W
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_flit_count <= '0;
    end else if (take) begin
      tx_flit_count <= tx_flit_count + CNT_W'(1);
    end
  end

endmodule

//--- verilog/lane_rx_align.sv
////////////////////////////////////////////////////////////////////////////
// Receive lane capture and flit reassembly
// Strobe agreement check and saturating strobe error counter
////////////////////////////////////////////////////////////////////////////

module lane_rx_align import lpif_link_pkg::*; (
  input  logic                         clk_wr,
  input  logic                         rst,
  input  logic                         rx_online_delay,
  input  logic [LANES-1:0][LANE_W-1:0] rx_lanes,
  output lpif_flit_t                   rx_word,
  output logic                         rx_word_valid,
  output logic [7:0]                   strobe_err_count
);

  logic [LANES-1:0]                 strb_q;
  logic [LANES-1:0][LANE_PAY_W-1:0] pay_q;
  logic [LANES*LANE_PAY_W-1:0]      gathered;
  logic                             strb_all;
  logic                             strb_none;
  logic                             strb_part;

  ////////////////////////////////////////////////////////////////////////////
  // Lane capture

  // Strobes reset so the error check starts clean
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      strb_q <= '0;
    end else begin
      for (int k = 0; k < LANES; k++) begin
        strb_q[k] <= rx_lanes[k][LANE_W-1];
      end
    end
  end

  always_ff @(posedge clk_wr) begin
    for (int k = 0; k < LANES; k++) begin
      pay_q[k] <= rx_lanes[k][LANE_PAY_W-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reassembly and qualification

  // Lane 0 lands in the low bits, padding above FLIT_W ignored
  assign gathered = pay_q;
  assign rx_word  = lpif_flit_t'(gathered[FLIT_W-1:0]);

  // Strobe class of the captured lane set
  assign strb_all  = &strb_q;
  assign strb_none = ~|strb_q;
  assign strb_part = !strb_all && !strb_none;

  assign rx_word_valid = strb_all && rx_online_delay && rx_word.valid;

  // Partial strobe set means the word is dropped
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      strobe_err_count <= '0;
    end else if (strb_part && strobe_err_count != 8'hff) begin
      strobe_err_count <= strobe_err_count + 8'd1;
    end
  end

endmodule

//--- verilog/flit_rx_unpack.sv
////////////////////////////////////////////////////////////////////////////
// Downstream flit output register and received flit counter
////////////////////////////////////////////////////////////////////////////

module flit_rx_unpack import lpif_link_pkg::*; #(
  parameter int CNT_W = 16
) (
  input  logic             clk_wr,
  input  logic             rst,
  input  lpif_flit_t       rx_word,
  input  logic             rx_word_valid,
  output lpif_flit_t       dstrm_flit,
  output logic [CNT_W-1:0] rx_flit_count
);

  ////////////////////////////////////////////////////////////////////////////
  // Qualifier bits

  // Forced low whenever no word is delivered
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      dstrm_flit.valid     <= 1'b0;
      dstrm_flit.crc_valid <= 1'b0;
      dstrm_flit.dvalid    <= 1'b0;
    end else if (rx_word_valid) begin
      dstrm_flit.valid     <= rx_word.valid;
      dstrm_flit.crc_valid <= rx_word.crc_valid;
      dstrm_flit.dvalid    <= rx_word.dvalid;
    end else begin
      dstrm_flit.valid     <= 1'b0;
      dstrm_flit.crc_valid <= 1'b0;
      dstrm_flit.dvalid    <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload fields

  // Hold last delivered value between flits
  always_ff @(posedge clk_wr) begin
    if (rx_word_valid) begin
      dstrm_flit.crc    <= rx_word.crc;
      dstrm_flit.data   <= rx_word.data;
      dstrm_flit.protid <= rx_word.protid;
      dstrm_flit.state  <= rx_word.state;
    end
  end

  // Wrapping count of delivered flits
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      rx_flit_count <= '0;
    end else if (rx_word_valid) begin
      rx_flit_count <= rx_flit_count + CNT_W'(1);
    end
  end

endmodule

//--- verilog/lpif_link_top.sv
////////////////////////////////////////////////////////////////////////////
// Top level of the reduced LPIF link over eight PHY lanes
// Online sync, tx striping, rx alignment, rx unpack and debug status words
////////////////////////////////////////////////////////////////////////////

module lpif_link_top import lpif_link_pkg::*; #(
  parameter int DELAY_W = 16,
  parameter int CNT_W   = 16
) (
  input  logic               clk_wr,
  input  logic               rst,

  // Control
  input  logic               tx_online,
  input  logic               rx_online,
  input  logic [DELAY_W-1:0] delay_x_value,
  input  logic [DELAY_W-1:0] delay_y_value,

  // PHY lanes
  output logic [LANE_W-1:0]  tx_phy0,
  output logic [LANE_W-1:0]  tx_phy1,
  output logic [LANE_W-1:0]  tx_phy2,
  output logic [LANE_W-1:0]  tx_phy3,
  output logic [LANE_W-1:0]  tx_phy4,
  output logic [LANE_W-1:0]  tx_phy5,
  output logic [LANE_W-1:0]  tx_phy6,
  output logic [LANE_W-1:0]  tx_phy7,
  input  logic [LANE_W-1:0]  rx_phy0,
  input  logic [LANE_W-1:0]  rx_phy1,
  input  logic [LANE_W-1:0]  rx_phy2,
  input  logic [LANE_W-1:0]  rx_phy3,
  input  logic [LANE_W-1:0]  rx_phy4,
  input  logic [LANE_W-1:0]  rx_phy5,
  input  logic [LANE_W-1:0]  rx_phy6,
  input  logic [LANE_W-1:0]  rx_phy7,

  // Upstream flit
  input  logic [3:0]         ustrm_state,
  input  logic [1:0]         ustrm_protid,
  input  logic [DATA_W-1:0]  ustrm_data,
  input  logic               ustrm_dvalid,
  input  logic [7:0]         ustrm_crc,
  input  logic               ustrm_crc_valid,
  input  logic               ustrm_valid,

  // Downstream flit
  output logic [3:0]         dstrm_state,
  output logic [1:0]         dstrm_protid,
  output logic [DATA_W-1:0]  dstrm_data,
  output logic               dstrm_dvalid,
  output logic [7:0]         dstrm_crc,
  output logic               dstrm_crc_valid,
  output logic               dstrm_valid,

  // Debug status
  output logic [31:0]        rx_downstream_debug_status,
  output logic [31:0]        tx_upstream_debug_status
);

  logic                         tx_online_delay;
  logic                         rx_online_delay;
  lpif_flit_t                   ustrm_flit;
  lpif_flit_t                   dstrm_flit;
  lpif_flit_t                   rx_word;
  logic                         rx_word_valid;
  logic [LANES-1:0][LANE_W-1:0] tx_lanes;
  logic [LANES-1:0][LANE_W-1:0] rx_lanes;
  logic [CNT_W-1:0]             tx_flit_count;
  logic [CNT_W-1:0]             rx_flit_count;
  logic [7:0]                   strobe_err_count;

  ////////////////////////////////////////////////////////////////////////////
  // Port mapping

  assign ustrm_flit.valid     = ustrm_valid;
  assign ustrm_flit.crc_valid = ustrm_crc_valid;
  assign ustrm_flit.crc       = ustrm_crc;
  assign ustrm_flit.dvalid    = ustrm_dvalid;
  assign ustrm_flit.data      = ustrm_data;
  assign ustrm_flit.protid    = ustrm_protid;
  assign ustrm_flit.state     = lpif_state_e'(ustrm_state);

  assign dstrm_valid     = dstrm_flit.valid;
  assign dstrm_crc_valid = dstrm_flit.crc_valid;
  assign dstrm_crc       = dstrm_flit.crc;
  assign dstrm_dvalid    = dstrm_flit.dvalid;
  assign dstrm_data      = dstrm_flit.data;
  assign dstrm_protid    = dstrm_flit.protid;
  assign dstrm_state     = dstrm_flit.state;

  assign tx_phy0 = tx_lanes[0];
  assign tx_phy1 = tx_lanes[1];
  assign tx_phy2 = tx_lanes[2];
  assign tx_phy3 = tx_lanes[3];
  assign tx_phy4 = tx_lanes[4];
  assign tx_phy5 = tx_lanes[5];
  assign tx_phy6 = tx_lanes[6];
  assign tx_phy7 = tx_lanes[7];

  assign rx_lanes = {rx_phy7, rx_phy6, rx_phy5, rx_phy4,
                     rx_phy3, rx_phy2, rx_phy1, rx_phy0};

  // Counts squeezed or padded to the 16-bit status field
  assign rx_downstream_debug_status = {strobe_err_count, 16'(rx_flit_count), 6'h0,
                                       tx_online_delay, rx_online_delay};
  assign tx_upstream_debug_status   = {8'h0, 16'(tx_flit_count), 6'h0,
                                       tx_online_delay, rx_online_delay};

  ////////////////////////////////////////////////////////////////////////////
  // Stages

  link_online_sync #(.DELAY_W(DELAY_W)) u_sync (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay)
  );

  flit_tx_stripe #(.CNT_W(CNT_W)) u_tx (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online_delay (tx_online_delay),
    .ustrm_flit      (ustrm_flit),
    .tx_lanes        (tx_lanes),
    .tx_flit_count   (tx_flit_count)
  );

  lane_rx_align u_rx_align (
    .clk_wr           (clk_wr),
    .rst              (rst),
    .rx_online_delay  (rx_online_delay),
    .rx_lanes         (rx_lanes),
    .rx_word          (rx_word),
    .rx_word_valid    (rx_word_valid),
    .strobe_err_count (strobe_err_count)
  );

  flit_rx_unpack #(.CNT_W(CNT_W)) u_rx_unpack (
    .clk_wr        (clk_wr),
    .rst           (rst),
    .rx_word       (rx_word),
    .rx_word_valid (rx_word_valid),
    .dstrm_flit    (dstrm_flit),
    .rx_flit_count (rx_flit_count)
  );

endmodule

//--- verif/lpif_link_checker.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent assertions on the LPIF link top level ports
// Reset quiet output, tx strobe agreement, zero lanes while tx offline
////////////////////////////////////////////////////////////////////////////

module lpif_link_checker import lpif_link_pkg::*; (
  input logic              clk_wr,
  input logic              rst,
  input logic              dstrm_valid,
  input logic [LANE_W-1:0] tx_phy0,
  input logic [LANE_W-1:0] tx_phy1,
  input logic [LANE_W-1:0] tx_phy2,
  input logic [LANE_W-1:0] tx_phy3,
  input logic [LANE_W-1:0] tx_phy4,
  input logic [LANE_W-1:0] tx_phy5,
  input logic [LANE_W-1:0] tx_phy6,
  input logic [LANE_W-1:0] tx_phy7,
  input logic [31:0]       tx_upstream_debug_status
);
  timeunit 1ns;
  timeprecision 100ps;

  int         fail_count = 0;
  logic [7:0] strobes;
  logic       lanes_zero;

  assign strobes = {tx_phy7[39], tx_phy6[39], tx_phy5[39], tx_phy4[39],
                    tx_phy3[39], tx_phy2[39], tx_phy1[39], tx_phy0[39]};
  assign lanes_zero = ~|{tx_phy0, tx_phy1, tx_phy2, tx_phy3,
                         tx_phy4, tx_phy5, tx_phy6, tx_phy7};

  // Nothing delivered during reset or in the first cycle after it
  a_rst_quiet: assert property (@(posedge clk_wr) (rst || $fell(rst)) |=> !dstrm_valid)
    else begin
      fail_count++;
      $error("dstrm_valid high during or right after reset");
    end

  a_strobe_equal: assert property (@(posedge clk_wr) disable iff (rst)
      (strobes == 8'h00 || strobes == 8'hff))
    else begin
      fail_count++;
      $error("tx lane strobes disagree");
    end

  // Lanes are registered from the online flag of the cycle before
  a_offline_zero: assert property (@(posedge clk_wr) disable iff (rst)
      !$past(tx_upstream_debug_status[1]) |-> lanes_zero)
    else begin
      fail_count++;
      $error("tx lanes not zero while tx path offline");
    end

endmodule

bind lpif_link_top lpif_link_checker u_checker (.*);

//--- verif/lpif_link_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the LPIF link with lane loopback and strobe fault injection
// Random flits checked against a queue model, per-test and summary lines
////////////////////////////////////////////////////////////////////////////

module lpif_link_tb import lpif_link_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic              clk_wr;
  logic              rst;
  logic              tx_online;
  logic              rx_online;
  logic [15:0]       delay_x_value;
  logic [15:0]       delay_y_value;
  logic [LANE_W-1:0] tx_phy0, tx_phy1, tx_phy2, tx_phy3;
  logic [LANE_W-1:0] tx_phy4, tx_phy5, tx_phy6, tx_phy7;
  logic [LANE_W-1:0] rx_phy0, rx_phy1, rx_phy2, rx_phy3;
  logic [LANE_W-1:0] rx_phy4, rx_phy5, rx_phy6, rx_phy7;
  logic [3:0]        ustrm_state;
  logic [1:0]        ustrm_protid;
  logic [DATA_W-1:0] ustrm_data;
  logic              ustrm_dvalid;
  logic [7:0]        ustrm_crc;
  logic              ustrm_crc_valid;
  logic              ustrm_valid;
  logic [3:0]        dstrm_state;
  logic [1:0]        dstrm_protid;
  logic [DATA_W-1:0] dstrm_data;
  logic              dstrm_dvalid;
  logic [7:0]        dstrm_crc;
  logic              dstrm_crc_valid;
  logic              dstrm_valid;
  logic [31:0]       rx_downstream_debug_status;
  logic [31:0]       tx_upstream_debug_status;
  logic [7:0]        strobe_clr;

  // Model state
  lpif_flit_t exp_q[$];
  int         due_q[$];
  int         seed = 81335;
  int         cyc, passes, fails, sent, delivered, faults;
  int         tx_hi, rx_hi, fault_next;
  bit         tx_live, rx_live, timeout_hit;

  lpif_link_top #(.DELAY_W(16), .CNT_W(16)) uut (.*);

  // Bit k of strobe_clr drops lane k's strobe in the loopback
  assign rx_phy0 = {tx_phy0[39] & ~strobe_clr[0], tx_phy0[38:0]};
  assign rx_phy1 = {tx_phy1[39] & ~strobe_clr[1], tx_phy1[38:0]};
  assign rx_phy2 = {tx_phy2[39] & ~strobe_clr[2], tx_phy2[38:0]};
  assign rx_phy3 = {tx_phy3[39] & ~strobe_clr[3], tx_phy3[38:0]};
  assign rx_phy4 = {tx_phy4[39] & ~strobe_clr[4], tx_phy4[38:0]};
  assign rx_phy5 = {tx_phy5[39] & ~strobe_clr[5], tx_phy5[38:0]};
  assign rx_phy6 = {tx_phy6[39] & ~strobe_clr[6], tx_phy6[38:0]};
  assign rx_phy7 = {tx_phy7[39] & ~strobe_clr[7], tx_phy7[38:0]};

  always #10 clk_wr = ~clk_wr;

  task automatic check_value(string name, logic [255:0] act, logic [255:0] exp);
    if (act !== exp) begin
      fails++;
      $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, act, exp);
    end else begin
      passes++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One clock cycle of model update, output checks and fault mask

  task automatic step();
    int lim_x;
    int lim_y;
    @(posedge clk_wr);
    cyc++;
    // Online flag after delay cycles of high input with a minimum of one
    lim_x = (delay_x_value == 0) ? 1 : int'(delay_x_value);
    lim_y = (delay_y_value == 0) ? 1 : int'(delay_y_value);
    tx_hi = tx_online ? tx_hi + 1 : 0;
    rx_hi = rx_online ? rx_hi + 1 : 0;
    tx_live = (tx_hi >= lim_x);
    rx_live = (rx_hi >= lim_y);
    #1;
    check_value("tx_upstream_debug_status[1:0]", tx_upstream_debug_status[1:0],
                {tx_live, rx_live});
    check_value("rx_downstream_debug_status[1:0]", rx_downstream_debug_status[1:0],
                {tx_live, rx_live});
    if (due_q.size() > 0 && due_q[0] == cyc) begin
      check_value("dstrm_valid", dstrm_valid, 1);
      check_value("dstrm_crc_valid", dstrm_crc_valid, exp_q[0].crc_valid);
      check_value("dstrm_crc", dstrm_crc, exp_q[0].crc);
      check_value("dstrm_dvalid", dstrm_dvalid, exp_q[0].dvalid);
      check_value("dstrm_data", dstrm_data, exp_q[0].data);
      check_value("dstrm_protid", dstrm_protid, exp_q[0].protid);
      check_value("dstrm_state", dstrm_state, exp_q[0].state);
      void'(exp_q.pop_front());
      void'(due_q.pop_front());
    end else begin
      check_value("dstrm_valid", dstrm_valid, 0);
      check_value("dstrm_dvalid", dstrm_dvalid, 0);
      check_value("dstrm_crc_valid", dstrm_crc_valid, 0);
    end
    #1;
    strobe_clr = '0;
    if (fault_next >= 0) strobe_clr[fault_next] = 1'b1;
    fault_next = -1;
  endtask

  // Drive a random flit; the model takes it if both paths are live
  task automatic send(bit want_valid, bit fault);
    logic [31:0] r;
    lpif_flit_t  f;
    r = $random(seed);
    ustrm_valid     = want_valid;
    ustrm_crc_valid = r[0];
    ustrm_dvalid    = r[1];
    ustrm_protid    = r[3:2];
    ustrm_state     = r[7:4];
    ustrm_crc       = r[15:8];
    for (int i = 0; i < 8; i++) ustrm_data[i*32 +: 32] = $random(seed);
    f = {ustrm_valid, ustrm_crc_valid, ustrm_crc, ustrm_dvalid,
         ustrm_data, ustrm_protid, ustrm_state};
    if (want_valid && tx_live && rx_live) begin
      sent++;
      if (fault) begin
        fault_next = $unsigned($random(seed)) % 8;
        faults++;
      end else begin
        exp_q.push_back(f);
        due_q.push_back(cyc + 3);
        delivered++;
      end
    end
  endtask

  function automatic bit coin70();
    return ($unsigned($random(seed)) % 100) < 70;
  endfunction

  task automatic report_test(string name, int start);
    $display("test %s finished with %0d errors", name, fails - start);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    int start;
    int n;
    int dx;
    int dy;
    int rise_x;
    int rise_y;
    clk_wr = 1'b0;
    rst = 1'b1;
    tx_online = 1'b0;
    rx_online = 1'b0;
    delay_x_value = '0;
    delay_y_value = '0;
    ustrm_valid = 1'b0;
    ustrm_crc_valid = 1'b0;
    ustrm_dvalid = 1'b0;
    ustrm_crc = '0;
    ustrm_protid = '0;
    ustrm_state = '0;
    ustrm_data = '0;
    strobe_clr = '0;
    fault_next = -1;
    repeat (5) @(posedge clk_wr);
    #2;
    rst = 1'b0;

    // Reset values, then both online flags after their delays
    start = fails;
    check_value("dstrm_valid", dstrm_valid, 0);
    check_value("tx_phy0", tx_phy0, 0);
    check_value("rx_downstream_debug_status", rx_downstream_debug_status, 0);
    check_value("tx_upstream_debug_status", tx_upstream_debug_status, 0);
    dx = 2 + $unsigned($random(seed)) % 19;
    dy = 2 + $unsigned($random(seed)) % 19;
    delay_x_value = 16'(dx);
    delay_y_value = 16'(dy);
    tx_online = 1'b1;
    rx_online = 1'b1;
    rise_x = 0;
    rise_y = 0;
    for (n = 1; n <= 100 && (rise_x == 0 || rise_y == 0); n++) begin
      step();
      if (rise_x == 0 && tx_upstream_debug_status[1]) rise_x = n;
      if (rise_y == 0 && rx_downstream_debug_status[0]) rise_y = n;
    end
    if (rise_x == 0 || rise_y == 0) begin
      $display("Timeout: online flags did not rise within 100 cycles");
      timeout_hit = 1'b1;
    end
    check_value("tx online delay cycles", rise_x, dx);
    check_value("rx online delay cycles", rise_y, dy);
    report_test("reset and online delay", start);

    if (!timeout_hit) begin
      start = fails;
      repeat (200) begin
        send(coin70(), 1'b0);
        step();
      end
      report_test("random flit loopback", start);

      // Flits keep coming while the tx path goes offline
      start = fails;
      tx_online = 1'b0;
      for (n = 0; n < 10 && tx_upstream_debug_status[1]; n++) begin
        send(1'b1, 1'b0);
        step();
      end
      if (tx_upstream_debug_status[1]) begin
        $display("Timeout: tx online flag did not fall within 10 cycles");
        timeout_hit = 1'b1;
      end
      repeat (20) begin
        send(1'b1, 1'b0);
        step();
      end
      check_value("tx_flit_count", tx_upstream_debug_status[23:8], 16'(sent));
      report_test("offline drop", start);
    end

    if (!timeout_hit) begin
      start = fails;
      tx_online = 1'b1;
      for (n = 0; n < 40 && !tx_upstream_debug_status[1]; n++) begin
        send(1'b0, 1'b0);
        step();
      end
      if (!tx_upstream_debug_status[1]) begin
        $display("Timeout: tx online flag did not rise again within 40 cycles");
        timeout_hit = 1'b1;
      end
      // Every tenth cycle carries a flit with one strobe dropped
      for (int i = 0; i < 100; i++) begin
        if (i % 10 == 5) send(1'b1, 1'b1);
        else send(coin70(), 1'b0);
        step();
      end
      for (n = 0; n < 20 && (due_q.size() > 0 || n < 4); n++) begin
        send(1'b0, 1'b0);
        step();
      end
      if (due_q.size() > 0) begin
        $display("Timeout: %0d flits still undelivered after drain", due_q.size());
        timeout_hit = 1'b1;
      end
      check_value("strobe_err_count", rx_downstream_debug_status[31:24], faults);
      report_test("strobe fault", start);

      start = fails;
      check_value("tx_flit_count", tx_upstream_debug_status[23:8], 16'(sent));
      check_value("rx_flit_count", rx_downstream_debug_status[23:8], 16'(delivered));
      report_test("counters", start);
    end

    $display("Checks passed %0d, failed %0d, assertion failures %0d",
             passes, fails, uut.u_checker.fail_count);
    if (fails == 0 && uut.u_checker.fail_count == 0 && !timeout_hit) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- build.f
verilog/lpif_link_pkg.sv
verilog/link_online_sync.sv
verilog/flit_tx_stripe.sv
verilog/lane_rx_align.sv
verilog/flit_rx_unpack.sv
verilog/lpif_link_top.sv
verif/lpif_link_checker.sv
verif/lpif_link_tb.sv

//--- Bender.yml
package:
  name: lpif_link

sources:
  - files:
      - verilog/lpif_link_pkg.sv
      - verilog/link_online_sync.sv
      - verilog/flit_tx_stripe.sv
      - verilog/lane_rx_align.sv
      - verilog/flit_rx_unpack.sv
      - verilog/lpif_link_top.sv
  - target: test
    files:
      - verif/lpif_link_checker.sv
      - verif/lpif_link_tb.sv
